//--- sources.f
source/soc_map_pkg.sv
source/soc_bus_pkg.sv
source/soc_bus_decode.sv
source/soc_sysctl.sv
source/soc_uart_tx.sv
source/soc_boot_ram.sv
source/soc_top.sv
dv/soc_checker.sv
dv/tb_soc.sv

//--- Bender.yml
package:
  name: soc_interconnect

sources:
  - source/soc_map_pkg.sv
  - source/soc_bus_pkg.sv
  - source/soc_bus_decode.sv
  - source/soc_sysctl.sv
  - source/soc_uart_tx.sv
  - source/soc_boot_ram.sv
  - source/soc_top.sv
  - target: test
    files:
      - dv/soc_checker.sv
      - dv/tb_soc.sv

//--- dv/tb_soc.sv
// Testbench for the interconnect. Plays the processor on the bus and
// applies a stimulus table in a loop, one access per entry.
// Expected values travel to the checker alongside each request.

`timescale 1ns/1ns

module tb_soc
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
();

  typedef struct packed {
    logic [8*12-1:0]   name;
    logic              instr;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [WORD_W-1:0] exp_rdata;
    logic              exp_fault;
    logic              exp_reboot;
    logic [7:0]        gap;
  } access_t;

  logic              clk;
  logic              resetn;
  bus_req_t          bus_req;
  bus_rsp_t          bus_rsp;
  logic              uart_tx;
  logic              reboot;
  logic [8*12-1:0]   cur_name;
  logic [WORD_W-1:0] exp_rdata;
  logic              exp_fault;
  logic              exp_reboot;
  logic              done;
  int                errors;
  logic              stim_built;
  access_t           stim [$];
  logic [WORD_W-1:0] shadow [RAM_WORDS];

  soc_top soc_top_inst (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .uart_tx_o (uart_tx),
    .reboot_o  (reboot)
  );

  soc_checker checker_inst (
    .clk          (clk),
    .resetn       (resetn),
    .bus_req_i    (bus_req),
    .bus_rsp_i    (bus_rsp),
    .uart_tx_i    (uart_tx),
    .reboot_i     (reboot),
    .name_i       (cur_name),
    .exp_rdata_i  (exp_rdata),
    .exp_fault_i  (exp_fault),
    .exp_reboot_i (exp_reboot),
    .exp_byte_i   (8'hA5),
    .done_i       (done),
    .errors_o     (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus table

  // gap is the number of idle cycles before the access
  task automatic add_access(input logic [8*12-1:0] name, input logic instr,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic [31:0] exp,
                            input logic fault, input int gap);
    stim.push_back({name, instr, addr, wdata, wstrb, exp, fault, 1'b0, 8'(gap)});
  endtask

  // full word write to the reboot register, pulse marks a key match
  task automatic reboot_write(input logic [8*12-1:0] name, input logic [31:0] wdata,
                              input logic pulse);
    stim.push_back({name, 1'b0, REBOOT_ADDR, wdata, 4'hF, 32'h0, 1'b0, pulse, 8'd0});
  endtask

  task automatic ram_write(input logic [8*12-1:0] name, input int idx,
                           input logic [3:0] strb);
    logic [31:0] data;
    data = $urandom;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
    end
    add_access(name, 1'b0, 32'(idx * 4), data, strb, '0, 1'b0, 0);
  endtask

  task automatic build_stimulus();
    int idx;
    for (int n = 0; n < 4; n++) begin
      idx = $urandom_range(0, RAM_WORDS - 1);
      ram_write("ram_wr_full", idx, 4'hF);
      ram_write("ram_wr_strb", idx, 4'($urandom_range(1, 14)));
      add_access("ram_rd", 1'b0, 32'(idx * 4), '0, '0, shadow[idx], 1'b0, 0);
    end
    add_access("ram_fetch", 1'b1, 32'(idx * 4), '0, '0, shadow[idx], 1'b0, 0);
    add_access("sys_freq", 1'b0, CPU_FREQ_ADDR, '0, '0, SYSTEM_CLK_HZ, 1'b0, 0);
    add_access("sys_memsize", 1'b0, MEM_SIZE_ADDR, '0, '0, MEM_SIZE_BYTES, 1'b0, 0);
    add_access("div_reset", 1'b0, DIV_ADDR, '0, '0, {16'h0, DIV_RESET}, 1'b0, 0);
    add_access("div_write", 1'b0, DIV_ADDR, 32'd8, 4'b0011, '0, 1'b0, 0);
    add_access("div_read", 1'b0, DIV_ADDR, '0, '0, 32'd8, 1'b0, 0);
    // one frame of 0xa5, a dropped byte mid-frame, status before and after
    add_access("uart_data", 1'b0, UART_DATA_ADDR, 32'hA5, 4'h1, '0, 1'b0, 0);
    add_access("lsr_busy", 1'b0, UART_LSR_ADDR, '0, '0, '0, 1'b0, 0);
    add_access("uart_drop", 1'b0, UART_DATA_ADDR, 32'h3C, 4'h1, '0, 1'b0, 20);
    add_access("lsr_idle", 1'b0, UART_LSR_ADDR, '0, '0,
               (32'd1 << LSR_THRE_BIT) | (32'd1 << LSR_TEMT_BIT), 1'b0, 100);
    add_access("io_unused", 1'b0, 32'h1000_0100, '0, '0, '0, 1'b0, 0);
    add_access("bad_addr", 1'b0, 32'h4000_0000, '0, '0, '0, 1'b1, 0);
    add_access("bad_fetch", 1'b1, UART_DATA_ADDR, '0, '0, '0, 1'b1, 0);
    reboot_write("reboot_miss", 32'h1234, 1'b0);
    reboot_write("reboot_key", {16'h0, REBOOT_KEY}, 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus driver

  task automatic apply(input access_t a);
    bus_req    <= {1'b1, a.instr, a.addr, a.wdata, a.wstrb};
    cur_name   <= a.name;
    exp_rdata  <= a.exp_rdata;
    exp_fault  <= a.exp_fault;
    exp_reboot <= a.exp_reboot;
  endtask

  task automatic wait_ready();
    @(negedge clk);
    while (bus_rsp.ready !== 1'b1) @(negedge clk);
  endtask

  initial begin
    void'($urandom(37145));
    resetn     = 1'b0;
    bus_req    = '0;
    cur_name   = '0;
    exp_rdata  = '0;
    exp_fault  = 1'b0;
    exp_reboot = 1'b0;
    done       = 1'b0;
    stim_built = 1'b0;
    build_stimulus();
    stim_built = 1'b1;
    repeat (5) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < stim.size(); i++) begin
      if (stim[i].gap != 0) begin
        bus_req.valid <= 1'b0;
        repeat (stim[i].gap) @(posedge clk);
      end
      apply(stim[i]);
      wait_ready();
      // next request goes out back to back at this edge
      @(posedge clk);
    end
    bus_req.valid <= 1'b0;
    repeat (20) @(posedge clk);
    done <= 1'b1;
    @(posedge clk);
    $display("%0d accesses, %0d errors", stim.size(), errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog sized from the table plus two serial frames
  initial begin
    wait (stim_built);
    repeat (stim.size() * 4 + 2 * 10 * 65) @(posedge clk);
    $display("run timed out waiting for the bus, %0d errors so far", errors);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- dv/soc_checker.sv
// Bus and serial line monitor for the interconnect testbench.
// Compares each response, the reboot pulse and every serial frame with
// the expected values driven by the testbench, and counts mismatches.

`timescale 1ns/1ns

module soc_checker
  import soc_bus_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  bus_req_t          bus_req_i,
  input  bus_rsp_t          bus_rsp_i,
  input  logic              uart_tx_i,
  input  logic              reboot_i,
  input  logic [8*12-1:0]   name_i,
  input  logic [WORD_W-1:0] exp_rdata_i,
  input  logic              exp_fault_i,
  input  logic              exp_reboot_i,
  input  logic [7:0]        exp_byte_i,
  input  logic              done_i,
  output int                errors_o
);

  // serial bit time once the divisor has been set to 8
  localparam int BIT_CYCLES = 8;

  int                bus_errs;
  int                line_errs;
  int                frames;
  logic              pending;
  logic              hit;
  logic [8*12-1:0]   name_q;
  logic [WORD_W-1:0] rdata_q;
  logic              fault_q;
  logic              reboot_q;

  assign errors_o = bus_errs + line_errs;

  //////////////////////////////////////////////////////////////////////
  // bus side, sampled mid-cycle

  initial begin
    bus_errs = 0;
    pending  = 1'b0;
  end

  always @(negedge clk) begin
    if (!resetn) begin
      pending = 1'b0;
    end else begin
      hit = pending && bus_rsp_i.ready;
      if (pending && !bus_rsp_i.ready) begin
        bus_errs++;
        $display("%0s got no ready one cycle after it was accepted", name_q);
      end
      if (!pending && bus_rsp_i.ready) begin
        bus_errs++;
        $display("ready came late or with no request pending");
      end
      if (hit && (bus_rsp_i.rdata !== rdata_q)) begin
        bus_errs++;
        $display("Error %0s: expected %h actual %h", name_q, rdata_q, bus_rsp_i.rdata);
      end
      if (hit && (bus_rsp_i.fault !== fault_q)) begin
        bus_errs++;
        $display("Error %0s: expected fault %b actual %b", name_q, fault_q, bus_rsp_i.fault);
      end
      // reboot pulses in the ready cycle of a key write and nowhere else
      if (reboot_i !== (hit && reboot_q)) begin
        bus_errs++;
        $display("Error %0s: expected reboot %b actual %b", name_q, hit && reboot_q, reboot_i);
      end
      // a request without ready now is taken at the next edge
      pending = bus_req_i.valid && !bus_rsp_i.ready;
      if (pending) begin
        name_q   = name_i;
        rdata_q  = exp_rdata_i;
        fault_q  = exp_fault_i;
        reboot_q = exp_reboot_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // serial line, one frame per falling edge

  initial begin
    logic [7:0] data;
    line_errs = 0;
    frames    = 0;
    @(posedge resetn);
    forever begin
      @(negedge uart_tx_i);
      frames++;
      repeat (BIT_CYCLES / 2) @(negedge clk);
      if (uart_tx_i !== 1'b0) begin
        line_errs++;
        $display("serial start bit did not stay low");
      end
      // lsb first
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        data[i] = uart_tx_i;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      if (uart_tx_i !== 1'b1) begin
        line_errs++;
        $display("serial stop bit was not high");
      end
      if (data !== exp_byte_i) begin
        line_errs++;
        $display("Error uart_frame: expected %h actual %h", exp_byte_i, data);
      end
    end
  end

  // the dropped byte must not add a second frame
  initial begin
    @(posedge done_i);
    if (frames != 1) begin
      line_errs++;
      $display("expected exactly one serial frame on the line, saw %0d", frames);
    end
  end

endmodule

//--- source/soc_top.sv
// Memory-side interconnect top. Decodes bus requests to the boot RAM,
// UART and system registers, and merges their answers into one response.

`timescale 1ns/1ns

module soc_top
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic     clk,
  input  logic     resetn,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     uart_tx_o,
  output logic     reboot_o
);

  target_e           sel;
  logic              write;
  logic              busy_q;
  logic              silent_q;
  logic              fault_q;
  logic              wr_q;
  logic              ram_ready, uart_ready, sys_ready;
  logic [WORD_W-1:0] ram_rdata, uart_rdata, sys_rdata;
  logic [15:0]       uart_div;

  soc_bus_decode u_decode (
    .bus_req_i (bus_req_i),
    .busy_i    (busy_q),
    .sel_o     (sel),
    .write_o   (write)
  );

  soc_boot_ram u_ram (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req_i (bus_req_i),
    .sel_i     (sel == RAM),
    .ready_o   (ram_ready),
    .rdata_o   (ram_rdata)
  );

  soc_uart_tx u_uart (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req_i (bus_req_i),
    .sel_i     (sel == UART),
    .div_i     (uart_div),
    .ready_o   (uart_ready),
    .rdata_o   (uart_rdata),
    .uart_tx_o (uart_tx_o)
  );

  soc_sysctl u_sysctl (
    .clk        (clk),
    .resetn     (resetn),
    .bus_req_i  (bus_req_i),
    .sel_i      (sel == SYSCTL),
    .ready_o    (sys_ready),
    .rdata_o    (sys_rdata),
    .uart_div_o (uart_div),
    .reboot_o   (reboot_o)
  );

  //////////////////////////////////////////////////////////////////////
  // accept state
  // busy covers the ready cycle so a held request is taken once

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q   <= 1'b0;
      silent_q <= 1'b0;
      fault_q  <= 1'b0;
      wr_q     <= 1'b0;
    end else begin
      busy_q   <= (sel != NONE);
      silent_q <= (sel == SILENT);
      fault_q  <= (sel == FAULT);
      wr_q     <= write;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response merge

  always_comb begin
    bus_rsp_o.ready = ram_ready | uart_ready | sys_ready | silent_q | fault_q;
    bus_rsp_o.fault = fault_q;
    bus_rsp_o.rdata = '0;
    // writes, silent and faulting accesses read as zero
    if (!wr_q) begin
      if (ram_ready)       bus_rsp_o.rdata = ram_rdata;
      else if (uart_ready) bus_rsp_o.rdata = uart_rdata;
      else if (sys_ready)  bus_rsp_o.rdata = sys_rdata;
    end
  end

endmodule

//--- source/soc_boot_ram.sv
// Boot block RAM, word organized with byte strobes.
// Read data and ready both appear one cycle after the select.

`timescale 1ns/1ns

module soc_boot_ram
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  bus_req_t          bus_req_i,
  input  logic              sel_i,
  output logic              ready_o,
  output logic [WORD_W-1:0] rdata_o
);

  logic [WORD_W-1:0]     mem [RAM_WORDS];
  logic [RAM_ADDR_W-1:0] idx;

  // byte address to word index
  assign idx = bus_req_i.addr[RAM_ADDR_W+1:2];

  always_ff @(posedge clk) begin
    if (sel_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus_req_i.wstrb[b]) mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
      end
      rdata_o <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) ready_o <= 1'b0;
    else ready_o <= sel_i;
  end

endmodule

//--- source/soc_uart_tx.sv
// Serial transmitter with data and line-status registers.
// One byte per accepted data write, 8N1, bit time set by div_i.

`timescale 1ns/1ns

module soc_uart_tx
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  bus_req_t          bus_req_i,
  input  logic              sel_i,
  input  logic [15:0]       div_i,
  output logic              ready_o,
  output logic [WORD_W-1:0] rdata_o,
  output logic              uart_tx_o
);

  logic        write;
  logic        start;
  logic        bit_end;
  logic [15:0] period;
  logic        busy_q;
  logic [9:0]  shift_q;
  logic [15:0] cnt_q;
  logic [3:0]  bit_q;

  assign write = |bus_req_i.wstrb;

  // writes arriving mid-frame are acknowledged and lost
  assign start = sel_i && write && (bus_req_i.addr == UART_DATA_ADDR) && !busy_q;

  // zero divisor behaves as one
  assign period  = (div_i == 16'd0) ? 16'd1 : div_i;
  assign bit_end = (cnt_q == period - 16'd1);

  //////////////////////////////////////////////////////////////////////
  // serializer

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q  <= 1'b0;
      shift_q <= '1;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else if (start) begin
      busy_q  <= 1'b1;
      // stop, data, start; the lsb goes out first
      shift_q <= {1'b1, bus_req_i.wdata[7:0], 1'b0};
      cnt_q   <= '0;
      bit_q   <= '0;
    end else if (busy_q) begin
      if (bit_end) begin
        cnt_q   <= '0;
        shift_q <= {1'b1, shift_q[9:1]};
        bit_q   <= bit_q + 4'd1;
        if (bit_q == 4'd9) busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 16'd1;
      end
    end
  end

  // line idles high since ones shift in behind the frame
  assign uart_tx_o = shift_q[0];

  //////////////////////////////////////////////////////////////////////
  // bus side

  always_ff @(posedge clk) begin
    if (!resetn) ready_o <= 1'b0;
    else ready_o <= sel_i;
  end

  always_ff @(posedge clk) begin
    if (sel_i) begin
      rdata_o <= '0;
      if (bus_req_i.addr == UART_LSR_ADDR) begin
        rdata_o[LSR_THRE_BIT] <= !busy_q;
        rdata_o[LSR_TEMT_BIT] <= !busy_q;
      end
    end
  end

endmodule

//--- source/soc_sysctl.sv
// System control registers: serial divisor, clock frequency, memory size
// and the reboot trigger. Answers one cycle after its select.

`timescale 1ns/1ns

module soc_sysctl
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
(
  input  logic              clk,
  input  logic              resetn,
  input  bus_req_t          bus_req_i,
  input  logic              sel_i,
  output logic              ready_o,
  output logic [WORD_W-1:0] rdata_o,
  output logic [15:0]       uart_div_o,
  output logic              reboot_o
);

  logic        write;
  logic        reboot_hit;
  logic [15:0] div_q;

  assign write = |bus_req_i.wstrb;

  assign reboot_hit = sel_i && write && (bus_req_i.addr == REBOOT_ADDR) &&
                      (bus_req_i.wdata[15:0] == REBOOT_KEY);

  // ready and the reboot pulse
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_o  <= 1'b0;
      reboot_o <= 1'b0;
    end else begin
      ready_o  <= sel_i;
      reboot_o <= reboot_hit;
    end
  end

  // divisor, byte lanes 0 and 1 only
  always_ff @(posedge clk) begin
    if (!resetn) begin
      div_q <= DIV_RESET;
    end else if (sel_i && write && (bus_req_i.addr == DIV_ADDR)) begin
      if (bus_req_i.wstrb[0]) div_q[7:0]  <= bus_req_i.wdata[7:0];
      if (bus_req_i.wstrb[1]) div_q[15:8] <= bus_req_i.wdata[15:8];
    end
  end

  // read mux, frequency and size are constants
  always_ff @(posedge clk) begin
    if (sel_i) begin
      case (bus_req_i.addr)
        DIV_ADDR:      rdata_o <= {16'h0000, div_q};
        CPU_FREQ_ADDR: rdata_o <= SYSTEM_CLK_HZ;
        MEM_SIZE_ADDR: rdata_o <= MEM_SIZE_BYTES;
        default:       rdata_o <= '0;
      endcase
    end
  end

  assign uart_div_o = div_q;

endmodule

//--- source/soc_bus_decode.sv
// Address decoder of the interconnect.
// Classifies a pending request into exactly one target or an access fault.

`timescale 1ns/1ns

module soc_bus_decode
  import soc_map_pkg::*;
  import soc_bus_pkg::*;
(
  input  bus_req_t bus_req_i,
  input  logic     busy_i,
  output target_e  sel_o,
  output logic     write_o
);

  logic in_ram;
  logic in_io;
  logic is_uart;
  logic is_sysctl;

  //////////////////////////////////////////////////////////////////////
  // address classification

  // ram occupies the bottom of the map
  assign in_ram = bus_req_i.addr < (RAM_WORDS * 4);

  assign in_io = (bus_req_i.addr >= IO_BASE) && (bus_req_i.addr <= IO_LAST);

  assign is_uart = (bus_req_i.addr == UART_DATA_ADDR) ||
                   (bus_req_i.addr == UART_LSR_ADDR);

  assign is_sysctl = (bus_req_i.addr == DIV_ADDR)      ||
                     (bus_req_i.addr == CPU_FREQ_ADDR) ||
                     (bus_req_i.addr == MEM_SIZE_ADDR) ||
                     (bus_req_i.addr == REBOOT_ADDR);

  assign write_o = |bus_req_i.wstrb;

  //////////////////////////////////////////////////////////////////////
  // target selection

  always_comb begin
    sel_o = NONE;
    if (bus_req_i.valid && !busy_i) begin
      if (in_ram) begin
        sel_o = RAM;
      end else if (bus_req_i.instr) begin
        // code runs from the boot ram only
        sel_o = FAULT;
      end else if (is_uart) begin
        sel_o = UART;
      end else if (is_sysctl) begin
        sel_o = SYSCTL;
      end else if (in_io) begin
        // unused i/o reads as zero without a fault
        sel_o = SILENT;
      end else begin
        sel_o = FAULT;
      end
    end
  end

endmodule

//--- source/soc_bus_pkg.sv
// Request and response types of the processor memory bus.
// A requester holds a request until it sees ready in the response.

package soc_bus_pkg;

  localparam int unsigned WORD_W = 32;
  localparam int unsigned STRB_W = 4;

  // request from the processor side
  // any set strobe bit makes the request a write
  typedef struct packed {
    logic              valid;
    logic              instr;
    logic [WORD_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } bus_req_t;

  // response back to the processor
  typedef struct packed {
    logic              ready;
    logic              fault;
    logic [WORD_W-1:0] rdata;
  } bus_rsp_t;

endpackage

//--- source/soc_map_pkg.sv
// Address map and fixed system values of the SoC interconnect.
// Imported by the decoder, the targets and the testbench.

package soc_map_pkg;

  //////////////////////////////////////////////////////////////////////
  // boot ram
  localparam int unsigned RAM_WORDS  = 1024;
  localparam int unsigned RAM_ADDR_W = $clog2(RAM_WORDS);

  //////////////////////////////////////////////////////////////////////
  // i/o window and register addresses
  localparam logic [31:0] IO_BASE = 32'h1000_0000;
  localparam logic [31:0] IO_LAST = 32'h1200_0000;

  localparam logic [31:0] UART_DATA_ADDR = 32'h1000_0000;
  localparam logic [31:0] UART_LSR_ADDR  = 32'h1000_0004;

  localparam logic [31:0] DIV_ADDR      = 32'h1000_0010;
  localparam logic [31:0] CPU_FREQ_ADDR = 32'h1000_0014;
  localparam logic [31:0] MEM_SIZE_ADDR = 32'h1000_0018;

  // reboot fires only when the low half of the data carries the key
  localparam logic [31:0] REBOOT_ADDR = 32'h1100_0000;
  localparam logic [15:0] REBOOT_KEY  = 16'h7777;

  //////////////////////////////////////////////////////////////////////
  // system values visible to software
  localparam logic [31:0] SYSTEM_CLK_HZ  = 32'd25_000_000;
  localparam logic [31:0] MEM_SIZE_BYTES = 32'd4096;

  // clock cycles per serial bit after reset
  localparam logic [15:0] DIV_RESET = 16'd16;

  // line status bits, 16550 positions shifted into the second byte
  localparam int unsigned LSR_THRE_BIT = 13;
  localparam int unsigned LSR_TEMT_BIT = 14;

  // one select per accepted request
  typedef enum logic [2:0] {
    NONE, RAM, UART, SYSCTL, SILENT, FAULT
  } target_e;

endpackage
